// ==== logic/conv_pkg.sv ====
package conv_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------
  parameter int ADDR_W = 12;     // sram word address
  parameter int DATA_W = 16;     // sram word, two pixels
  parameter int PIX_W  = 8;      // pixel and weight
  parameter int ACC_W  = 20;     // nine signed products and some headroom

  // ----------------------------------------------------------------------
  // limits and constants
  // ----------------------------------------------------------------------
  parameter int MAX_N = 64;                      // largest matrix side
  parameter logic [PIX_W-1:0] END_MARK = 8'hFF;  // header that stops a run
  parameter int KERNEL_WORDS = 5;                // 9 weights, last byte unused
  parameter int WINDOW_WORDS = 8;                // 4x4 window, 2 words per row
  parameter int RELU_MAX = 127;

  // run sequencer
  typedef enum logic [1:0] {
    RUN_IDLE,
    RUN_READ_HEADER,
    RUN_PROCESS,
    RUN_FINISH
  } run_state_t;

  // input sram reader
  typedef enum logic [2:0] {
    FETCH_IDLE,
    FETCH_HEADER_ADDR,
    FETCH_HEADER_DATA,
    FETCH_WORD_ADDR,
    FETCH_WORD_DATA,
    FETCH_HOLD
  } fetch_state_t;

  // conv / relu / pool datapath
  typedef enum logic [2:0] {
    ENG_IDLE,
    ENG_MAC,
    ENG_RELU,
    ENG_POOL,
    ENG_PACK,
    ENG_WRITE
  } engine_state_t;

endpackage

// ==== logic/run_control.sv ====
`timescale 1ns/1ps

module run_control (
  input  logic                       clk,
  input  logic                       reset_b,
  input  logic                       dut_run,
  input  logic                       header_valid,
  input  logic [conv_pkg::PIX_W-1:0] header_n,
  input  logic                       matrix_done,
  output logic                       dut_busy,
  output logic                       kernel_start,
  output logic                       header_start,
  output logic [conv_pkg::PIX_W-1:0] matrix_n
);

  conv_pkg::run_state_t state;

  // ----------------------------------------------------------------------
  // run sequencer
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state        <= conv_pkg::RUN_IDLE;
      dut_busy     <= 1'b0;
      kernel_start <= 1'b0;
      header_start <= 1'b0;
      matrix_n     <= '0;
    end
    else
    begin
      kernel_start <= 1'b0;   // both starts are single-cycle pulses
      header_start <= 1'b0;
      case (state)
        conv_pkg::RUN_IDLE:
        begin
          if (dut_run)
          begin
            // kernel load and first header read go out together
            dut_busy     <= 1'b1;
            kernel_start <= 1'b1;
            header_start <= 1'b1;
            state        <= conv_pkg::RUN_READ_HEADER;
          end
        end
        conv_pkg::RUN_READ_HEADER:
        begin
          if (header_valid)
          begin
            if (header_n == conv_pkg::END_MARK)
            begin
              state <= conv_pkg::RUN_FINISH;
            end
            else
            begin
              matrix_n <= header_n;   // held for the whole matrix
              state    <= conv_pkg::RUN_PROCESS;
            end
          end
        end
        conv_pkg::RUN_PROCESS:
        begin
          if (matrix_done)
          begin
            header_start <= 1'b1;   // on to the next header
            state        <= conv_pkg::RUN_READ_HEADER;
          end
        end
        conv_pkg::RUN_FINISH:
        begin
          dut_busy <= 1'b0;
          state    <= conv_pkg::RUN_IDLE;
        end
        default:
        begin
          state <= conv_pkg::RUN_IDLE;
        end
      endcase
    end
  end

endmodule

// ==== logic/kernel_loader.sv ====
`timescale 1ns/1ps

module kernel_loader #(
  parameter int ADDR_W = conv_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          reset_b,
  input  logic                          kernel_start,
  output logic [ADDR_W-1:0]             weights_sram_read_address,
  input  logic [conv_pkg::DATA_W-1:0]   weights_sram_read_data,
  output logic [9*conv_pkg::PIX_W-1:0]  kernel_weights,
  output logic                          kernel_valid
);

  localparam int IDX_W = $clog2(conv_pkg::KERNEL_WORDS);
  localparam int PIX_W = conv_pkg::PIX_W;

  logic             loading;
  logic             phase;      // 0 address cycle, 1 data cycle
  logic [IDX_W-1:0] word_idx;
  logic             last_word;

  assign weights_sram_read_address = ADDR_W'(word_idx);   // kernel sits at word 0
  assign last_word = (word_idx == IDX_W'(conv_pkg::KERNEL_WORDS - 1));

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      loading      <= 1'b0;
      phase        <= 1'b0;
      word_idx     <= '0;
      kernel_valid <= 1'b0;
    end
    else if (kernel_start)
    begin
      loading      <= 1'b1;
      phase        <= 1'b0;
      word_idx     <= '0;
      kernel_valid <= 1'b0;
    end
    else if (loading)
    begin
      phase <= !phase;
      if (phase)
      begin
        if (last_word)
        begin
          loading      <= 1'b0;
          kernel_valid <= 1'b1;
        end
        else
        begin
          word_idx <= word_idx + 1'b1;
        end
      end
    end
  end

  // high byte is the earlier weight in row-major order
  always_ff @(posedge clk)
  begin
    if (loading && phase)
    begin
      kernel_weights[2*word_idx*PIX_W +: PIX_W] <= weights_sram_read_data[15:8];
      if (!last_word)   // tenth byte is padding
      begin
        kernel_weights[(2*word_idx+1)*PIX_W +: PIX_W] <= weights_sram_read_data[7:0];
      end
    end
  end

endmodule

// ==== logic/window_fetch.sv ====
`timescale 1ns/1ps

module window_fetch #(
  parameter int ADDR_W = conv_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          reset_b,
  input  logic                          header_start,
  input  logic [conv_pkg::PIX_W-1:0]    matrix_n,
  output logic [ADDR_W-1:0]             input_sram_read_address,
  input  logic [conv_pkg::DATA_W-1:0]   input_sram_read_data,
  output logic                          header_valid,
  output logic [conv_pkg::PIX_W-1:0]    header_n,
  output logic [16*conv_pkg::PIX_W-1:0] window_pixels,
  output logic                          window_valid,
  input  logic                          window_ready
);

  localparam int PIX_W = conv_pkg::PIX_W;
  localparam int W_W   = $clog2(conv_pkg::WINDOW_WORDS);

  conv_pkg::fetch_state_t state;

  logic [ADDR_W-1:0]    hdr_ptr;    // header of the current matrix
  logic [ADDR_W-1:0]    win_base;   // first word of window row 0
  logic [ADDR_W-1:0]    row_off;    // window row offset, steps by N/2
  logic [ADDR_W-1:0]    stride;     // words per input row
  logic [W_W-1:0]       word_idx;
  logic [PIX_W-1:0]     pr;
  logic [PIX_W-1:0]     pc;
  logic [PIX_W-1:0]     last_pos;   // (N-2)/2 - 1
  logic [16*PIX_W-1:0]  asm_buf;    // window being assembled
  logic                 load;

  // matrix_n lands one cycle after header_valid; the first word of a
  // window never needs the stride, so it is in time
  assign stride   = ADDR_W'(matrix_n[PIX_W-1:1]);
  assign last_pos = matrix_n[PIX_W-1:1] - 8'd2;
  assign load     = (state == conv_pkg::FETCH_HOLD) && (!window_valid || window_ready);

  assign input_sram_read_address =
    (state == conv_pkg::FETCH_HEADER_ADDR) ? hdr_ptr :
    win_base + row_off + ADDR_W'(word_idx[0]);

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state        <= conv_pkg::FETCH_IDLE;
      hdr_ptr      <= '0;
      win_base     <= '0;
      row_off      <= '0;
      word_idx     <= '0;
      pr           <= '0;
      pc           <= '0;
      header_valid <= 1'b0;
    end
    else
    begin
      header_valid <= 1'b0;
      case (state)
        conv_pkg::FETCH_IDLE:
        begin
          if (header_start)
          begin
            state <= conv_pkg::FETCH_HEADER_ADDR;
          end
        end
        conv_pkg::FETCH_HEADER_ADDR:
        begin
          state <= conv_pkg::FETCH_HEADER_DATA;
        end
        conv_pkg::FETCH_HEADER_DATA:
        begin
          header_valid <= 1'b1;
          if (input_sram_read_data[PIX_W-1:0] == conv_pkg::END_MARK)
          begin
            hdr_ptr <= '0;   // next run reads from word 0 again
            state   <= conv_pkg::FETCH_IDLE;
          end
          else
          begin
            win_base <= hdr_ptr + 1'b1;
            row_off  <= '0;
            word_idx <= '0;
            pr       <= '0;
            pc       <= '0;
            state    <= conv_pkg::FETCH_WORD_ADDR;
          end
        end
        conv_pkg::FETCH_WORD_ADDR:
        begin
          state <= conv_pkg::FETCH_WORD_DATA;
        end
        conv_pkg::FETCH_WORD_DATA:
        begin
          word_idx <= word_idx + 1'b1;
          if (word_idx == W_W'(conv_pkg::WINDOW_WORDS - 1))
          begin
            row_off <= '0;
            state   <= conv_pkg::FETCH_HOLD;
          end
          else
          begin
            if (word_idx[0])
            begin
              row_off <= row_off + stride;
            end
            state <= conv_pkg::FETCH_WORD_ADDR;
          end
        end
        conv_pkg::FETCH_HOLD:
        begin
          if (load)
          begin
            state <= conv_pkg::FETCH_WORD_ADDR;
            if (pc == last_pos)
            begin
              pc <= '0;
              if (pr == last_pos)
              begin
                hdr_ptr <= win_base + (stride << 1) + stride + 2'd2;  // past the matrix
                state   <= conv_pkg::FETCH_IDLE;
              end
              else
              begin
                pr       <= pr + 1'b1;
                win_base <= win_base + stride + 2'd2;   // down two input rows
              end
            end
            else
            begin
              pc       <= pc + 1'b1;
              win_base <= win_base + 1'b1;
            end
          end
        end
        default:
        begin
          state <= conv_pkg::FETCH_IDLE;
        end
      endcase
    end
  end

  // one-window hold buffer toward the engine
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      window_valid <= 1'b0;
    end
    else if (load)
    begin
      window_valid <= 1'b1;
    end
    else if (window_ready)
    begin
      window_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == conv_pkg::FETCH_HEADER_DATA)
    begin
      header_n <= input_sram_read_data[PIX_W-1:0];
    end
    // high byte is the left pixel, so it takes the lower slot
    if (state == conv_pkg::FETCH_WORD_DATA)
    begin
      asm_buf[2*word_idx*PIX_W +: 2*PIX_W] <=
        {input_sram_read_data[7:0], input_sram_read_data[15:8]};
    end
    if (load)
    begin
      window_pixels <= asm_buf;
    end
  end

endmodule

// ==== logic/conv_pool_engine.sv ====
`timescale 1ns/1ps

module conv_pool_engine #(
  parameter int ADDR_W = conv_pkg::ADDR_W
) (
  input  logic                          clk,
  input  logic                          reset_b,
  input  logic [9*conv_pkg::PIX_W-1:0]  kernel_weights,
  input  logic                          kernel_valid,
  input  logic [16*conv_pkg::PIX_W-1:0] window_pixels,
  input  logic                          window_valid,
  output logic                          window_ready,
  input  logic [conv_pkg::PIX_W-1:0]    matrix_n,
  output logic                          output_sram_write_enable,
  output logic [ADDR_W-1:0]             output_sram_write_addresss,
  output logic [conv_pkg::DATA_W-1:0]   output_sram_write_data,
  output logic                          matrix_done
);

  localparam int PIX_W = conv_pkg::PIX_W;
  localparam int ACC_W = conv_pkg::ACC_W;
  localparam int CNT_W = 2 * $clog2(conv_pkg::MAX_N);

  conv_pkg::engine_state_t state;

  logic signed [PIX_W-1:0] win [16];
  logic signed [ACC_W-1:0] acc [4];     // 2x2 conv outputs of the window
  logic [PIX_W-1:0]        relu_val [4];
  logic [PIX_W-1:0]        pool_byte;
  logic [PIX_W-1:0]        pack_hi;
  logic [PIX_W-1:0]        max_top;
  logic [PIX_W-1:0]        max_bot;
  logic signed [PIX_W-1:0] wt;
  logic [3:0]              tap;
  logic [3:0]              pix_base;  // top-left pixel under the current tap
  logic [1:0]              kc;
  logic                    half;      // high byte already packed
  logic [PIX_W-1:0]        npool;
  logic [CNT_W-1:0]        res_cnt;
  logic [CNT_W-1:0]        res_total;
  logic                    last_res;
  logic                    take;

  assign window_ready = (state == conv_pkg::ENG_IDLE) && kernel_valid;
  assign take         = window_valid && window_ready;
  assign wt           = kernel_weights[tap*PIX_W +: PIX_W];

  assign npool     = matrix_n[PIX_W-1:1] - 1'b1;
  assign res_total = CNT_W'(npool) * CNT_W'(npool);
  assign last_res  = (res_cnt + 1'b1) == res_total;

  always_comb
  begin
    max_top = (relu_val[0] > relu_val[1]) ? relu_val[0] : relu_val[1];
    max_bot = (relu_val[2] > relu_val[3]) ? relu_val[2] : relu_val[3];
  end

  // ----------------------------------------------------------------------
  // control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      state                      <= conv_pkg::ENG_IDLE;
      tap                        <= '0;
      kc                         <= '0;
      pix_base                   <= '0;
      half                       <= 1'b0;
      res_cnt                    <= '0;
      output_sram_write_enable   <= 1'b0;
      output_sram_write_addresss <= '0;
      matrix_done                <= 1'b0;
    end
    else
    begin
      matrix_done <= 1'b0;
      case (state)
        conv_pkg::ENG_IDLE:
        begin
          if (!kernel_valid)
          begin
            output_sram_write_addresss <= '0;   // kernel reload means a new run
          end
          if (take)
          begin
            tap      <= '0;
            kc       <= '0;
            pix_base <= '0;
            state    <= conv_pkg::ENG_MAC;
          end
        end
        conv_pkg::ENG_MAC:
        begin
          if (tap == 4'd8)
          begin
            state <= conv_pkg::ENG_RELU;
          end
          else
          begin
            tap <= tap + 1'b1;
            if (kc == 2'd2)
            begin
              kc       <= '0;
              pix_base <= pix_base + 4'd2;   // wrap to next window row
            end
            else
            begin
              kc       <= kc + 1'b1;
              pix_base <= pix_base + 1'b1;
            end
          end
        end
        conv_pkg::ENG_RELU:
        begin
          state <= conv_pkg::ENG_POOL;
        end
        conv_pkg::ENG_POOL:
        begin
          state <= conv_pkg::ENG_PACK;
        end
        conv_pkg::ENG_PACK:
        begin
          half    <= !half && !last_res;
          res_cnt <= last_res ? '0 : res_cnt + 1'b1;
          if (half || last_res)
          begin
            output_sram_write_enable <= 1'b1;
            state                    <= conv_pkg::ENG_WRITE;
          end
          else
          begin
            state <= conv_pkg::ENG_IDLE;
          end
        end
        conv_pkg::ENG_WRITE:
        begin
          output_sram_write_enable   <= 1'b0;
          output_sram_write_addresss <= output_sram_write_addresss + 1'b1;
          matrix_done                <= (res_cnt == '0);  // only cleared by the last result
          state                      <= conv_pkg::ENG_IDLE;
        end
        default:
        begin
          state <= conv_pkg::ENG_IDLE;
        end
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // datapath
  // ----------------------------------------------------------------------
  always_ff @(posedge clk)
  begin
    case (state)
      conv_pkg::ENG_IDLE:
      begin
        if (take)
        begin
          for (int i = 0; i < 16; i++)
          begin
            win[i] <= window_pixels[i*PIX_W +: PIX_W];
          end
          for (int p = 0; p < 4; p++)
          begin
            acc[p] <= '0;
          end
        end
      end
      conv_pkg::ENG_MAC:
      begin
        acc[0] <= acc[0] + win[pix_base] * wt;
        acc[1] <= acc[1] + win[pix_base + 4'd1] * wt;
        acc[2] <= acc[2] + win[pix_base + 4'd4] * wt;
        acc[3] <= acc[3] + win[pix_base + 4'd5] * wt;
      end
      conv_pkg::ENG_RELU:
      begin
        for (int p = 0; p < 4; p++)
        begin
          if (acc[p] < 0)
            relu_val[p] <= '0;
          else if (acc[p] >= conv_pkg::RELU_MAX)
            relu_val[p] <= PIX_W'(conv_pkg::RELU_MAX);
          else
            relu_val[p] <= acc[p][PIX_W-1:0];
        end
      end
      conv_pkg::ENG_POOL:
      begin
        pool_byte <= (max_top > max_bot) ? max_top : max_bot;
      end
      conv_pkg::ENG_PACK:
      begin
        if (!half)
        begin
          pack_hi <= pool_byte;
        end
        // odd last byte goes out with a zero low byte
        output_sram_write_data <= half ? {pack_hi, pool_byte} : {pool_byte, 8'h00};
      end
      default:
      begin
      end
    endcase
  end

endmodule

// ==== logic/conv_accel_top.sv ====
`timescale 1ns/1ps

module conv_accel_top #(
  parameter int ADDR_W = conv_pkg::ADDR_W
) (
  input  logic                        clk,
  input  logic                        reset_b,
  input  logic                        dut_run,
  output logic                        dut_busy,
  output logic [ADDR_W-1:0]           input_sram_read_address,
  input  logic [conv_pkg::DATA_W-1:0] input_sram_read_data,
  output logic [ADDR_W-1:0]           weights_sram_read_address,
  input  logic [conv_pkg::DATA_W-1:0] weights_sram_read_data,
  output logic                        output_sram_write_enable,
  output logic [ADDR_W-1:0]           output_sram_write_addresss,
  output logic [conv_pkg::DATA_W-1:0] output_sram_write_data
);

  // sequencer handshakes
  logic                            kernel_start;
  logic                            header_start;
  logic                            header_valid;
  logic [conv_pkg::PIX_W-1:0]      header_n;
  logic [conv_pkg::PIX_W-1:0]      matrix_n;
  logic                            matrix_done;

  // kernel and window hand-off
  logic [9*conv_pkg::PIX_W-1:0]    kernel_weights;
  logic                            kernel_valid;
  logic [16*conv_pkg::PIX_W-1:0]   window_pixels;
  logic                            window_valid;
  logic                            window_ready;

  run_control u_run_control (
    .clk          (clk),
    .reset_b      (reset_b),
    .dut_run      (dut_run),
    .header_valid (header_valid),
    .header_n     (header_n),
    .matrix_done  (matrix_done),
    .dut_busy     (dut_busy),
    .kernel_start (kernel_start),
    .header_start (header_start),
    .matrix_n     (matrix_n)
  );

  kernel_loader #(.ADDR_W(ADDR_W)) u_kernel_loader (
    .clk                       (clk),
    .reset_b                   (reset_b),
    .kernel_start              (kernel_start),
    .weights_sram_read_address (weights_sram_read_address),
    .weights_sram_read_data    (weights_sram_read_data),
    .kernel_weights            (kernel_weights),
    .kernel_valid              (kernel_valid)
  );

  window_fetch #(.ADDR_W(ADDR_W)) u_window_fetch (
    .clk                     (clk),
    .reset_b                 (reset_b),
    .header_start            (header_start),
    .matrix_n                (matrix_n),
    .input_sram_read_address (input_sram_read_address),
    .input_sram_read_data    (input_sram_read_data),
    .header_valid            (header_valid),
    .header_n                (header_n),
    .window_pixels           (window_pixels),
    .window_valid            (window_valid),
    .window_ready            (window_ready)
  );

  conv_pool_engine #(.ADDR_W(ADDR_W)) u_conv_pool_engine (
    .clk                        (clk),
    .reset_b                    (reset_b),
    .kernel_weights             (kernel_weights),
    .kernel_valid               (kernel_valid),
    .window_pixels              (window_pixels),
    .window_valid               (window_valid),
    .window_ready               (window_ready),
    .matrix_n                   (matrix_n),
    .output_sram_write_enable   (output_sram_write_enable),
    .output_sram_write_addresss (output_sram_write_addresss),
    .output_sram_write_data     (output_sram_write_data),
    .matrix_done                (matrix_done)
  );

endmodule

// ==== tb/conv_accel_checker.sv ====
`timescale 1ns/1ps

module conv_accel_checker #(
  parameter int ADDR_W = conv_pkg::ADDR_W
) (
  input logic                        clk,
  input logic                        reset_b,
  input logic                        dut_run,
  input logic                        dut_busy,
  input logic                        output_sram_write_enable,
  input logic [ADDR_W-1:0]           output_sram_write_addresss,
  input logic [conv_pkg::DATA_W-1:0] output_sram_write_data
);

  logic [ADDR_W-1:0] next_addr;     // where the next write has to land
  int                write_count;   // writes since the run was accepted
  logic              run_taken;

  assign run_taken = dut_run && !dut_busy;

  always_ff @(posedge clk or negedge reset_b)
  begin
    if (!reset_b)
    begin
      next_addr   <= '0;
      write_count <= 0;
    end
    else if (run_taken)
    begin
      next_addr   <= '0;   // each run writes from address 0
      write_count <= 0;
    end
    else if (output_sram_write_enable)
    begin
      next_addr   <= next_addr + 1'b1;
      write_count <= write_count + 1;
    end
  end

  // ----------------------------------------------------------------------
  // run / busy handshake
  // ----------------------------------------------------------------------
  reset_quiet: assert property (@(posedge clk)
    $rose(reset_b) |-> !dut_busy && !output_sram_write_enable)
  else
  begin
    $error("ERROR t=%0t busy or write enable high after reset", $time);
    conv_accel_tb.fail_run();
  end

  busy_follows_run: assert property (@(posedge clk) disable iff (!reset_b)
    run_taken |=> dut_busy)
  else
  begin
    $error("ERROR t=%0t dut_busy did not rise one cycle after dut_run", $time);
    conv_accel_tb.fail_run();
  end

  busy_needs_run: assert property (@(posedge clk) disable iff (!reset_b)
    $rose(dut_busy) |-> $past(dut_run))
  else
  begin
    $error("ERROR t=%0t dut_busy rose without a dut_run pulse", $time);
    conv_accel_tb.fail_run();
  end

  // ----------------------------------------------------------------------
  // output sram writes
  // ----------------------------------------------------------------------
  write_while_busy: assert property (@(posedge clk) disable iff (!reset_b)
    output_sram_write_enable |-> dut_busy)
  else
  begin
    $error("ERROR t=%0t write to address %0d while idle", $time,
           $sampled(output_sram_write_addresss));
    conv_accel_tb.fail_run();
  end

  write_address: assert property (@(posedge clk) disable iff (!reset_b)
    output_sram_write_enable |-> output_sram_write_addresss == next_addr)
  else
  begin
    $error("ERROR t=%0t write address %0d, expected %0d", $time,
           $sampled(output_sram_write_addresss), $sampled(next_addr));
    conv_accel_tb.fail_run();
  end

  write_data: assert property (@(posedge clk) disable iff (!reset_b)
    output_sram_write_enable |->
      output_sram_write_data == conv_accel_tb.expected_mem[output_sram_write_addresss])
  else
  begin
    $error("ERROR t=%0t address %0d data %h, expected %h", $time,
           $sampled(output_sram_write_addresss), $sampled(output_sram_write_data),
           conv_accel_tb.expected_mem[$sampled(output_sram_write_addresss)]);
    conv_accel_tb.fail_run();
  end

  // word count checked on the falling edge of busy
  write_total: assert property (@(posedge clk) disable iff (!reset_b)
    $fell(dut_busy) |-> write_count == conv_accel_tb.expected_count)
  else
  begin
    $error("ERROR t=%0t run ended after %0d writes, expected %0d", $time,
           $sampled(write_count), conv_accel_tb.expected_count);
    conv_accel_tb.fail_run();
  end

endmodule

// ==== tb/conv_accel_tb.sv ====
`timescale 1ns/1ps

module conv_accel_tb;

  localparam int ADDR_W = conv_pkg::ADDR_W;
  localparam int DATA_W = conv_pkg::DATA_W;
  localparam int DEPTH  = 1 << ADDR_W;
  localparam int TEST_SIZES [6] = '{8, 6, 6, 6, 4, 10};  // every matrix of every run

  logic              clk;
  logic              reset_b;
  logic              dut_run;
  logic              dut_busy;
  logic [ADDR_W-1:0] input_sram_read_address;
  logic [DATA_W-1:0] input_sram_read_data;
  logic [ADDR_W-1:0] weights_sram_read_address;
  logic [DATA_W-1:0] weights_sram_read_data;
  logic              output_sram_write_enable;
  logic [ADDR_W-1:0] output_sram_write_addresss;
  logic [DATA_W-1:0] output_sram_write_data;

  logic [DATA_W-1:0] input_mem [DEPTH];
  logic [DATA_W-1:0] weights_mem [DEPTH];
  logic [DATA_W-1:0] expected_mem [DEPTH];   // read by the bound checker
  int                expected_count;
  logic [31:0]       lcg_state = 32'h4e5d_32b5;

  conv_accel_top #(.ADDR_W(ADDR_W)) DUT (
    .clk                        (clk),
    .reset_b                    (reset_b),
    .dut_run                    (dut_run),
    .dut_busy                   (dut_busy),
    .input_sram_read_address    (input_sram_read_address),
    .input_sram_read_data       (input_sram_read_data),
    .weights_sram_read_address  (weights_sram_read_address),
    .weights_sram_read_data     (weights_sram_read_data),
    .output_sram_write_enable   (output_sram_write_enable),
    .output_sram_write_addresss (output_sram_write_addresss),
    .output_sram_write_data     (output_sram_write_data)
  );

  bind conv_accel_top conv_accel_checker #(.ADDR_W(ADDR_W)) u_checker (
    .clk                        (clk),
    .reset_b                    (reset_b),
    .dut_run                    (dut_run),
    .dut_busy                   (dut_busy),
    .output_sram_write_enable   (output_sram_write_enable),
    .output_sram_write_addresss (output_sram_write_addresss),
    .output_sram_write_data     (output_sram_write_data)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #10 clk = ~clk;
    end
  end

  // both srams answer one cycle after the address
  always @(posedge clk)
  begin
    input_sram_read_data   <= #2 input_mem[input_sram_read_address];
    weights_sram_read_data <= #2 weights_mem[weights_sram_read_address];
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  function automatic logic [7:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[23:16];
  endfunction

  function automatic int pooled_count(input int n);
    return ((n - 2) / 2) * ((n - 2) / 2);
  endfunction

  // pixel (r, c) of the matrix whose first word is at base
  function automatic int pixel_at(input int base, input int n, input int r, input int c);
    logic [DATA_W-1:0] word;
    word = input_mem[base + (r * n + c) / 2];
    if (c % 2 == 0)
      return $signed(word[15:8]);   // left pixel in the high byte
    else
      return $signed(word[7:0]);
  endfunction

  function automatic int weight_at(input int k);
    logic [DATA_W-1:0] word;
    word = weights_mem[k / 2];
    if (k % 2 == 0)
      return $signed(word[15:8]);
    else
      return $signed(word[7:0]);
  endfunction

  task automatic fail_run();
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  // mode 0 random, 1 all +127, 2 all -128
  task automatic load_kernel(input int mode);
    logic [7:0] w [10];
    for (int k = 0; k < 9; k++)
    begin
      case (mode)
        1:       w[k] = 8'h7f;
        2:       w[k] = 8'h80;
        default: w[k] = next_random();
      endcase
    end
    w[9] = next_random();   // padding byte
    for (int i = 0; i < 5; i++)
    begin
      weights_mem[i] = {w[2 * i], w[2 * i + 1]};
    end
  endtask

  task automatic place_matrix(inout int ptr, input int n, input bit positive);
    logic [7:0] hi;
    logic [7:0] lo;
    input_mem[ptr] = {next_random(), 8'(n)};   // header, n in the low byte
    for (int i = 1; i <= n * n / 2; i++)
    begin
      hi = next_random();
      lo = next_random();
      if (positive)
      begin
        hi = {1'b0, hi[6:0]} | 8'h01;
        lo = {1'b0, lo[6:0]} | 8'h01;
      end
      input_mem[ptr + i] = {hi, lo};
    end
    ptr += 1 + n * n / 2;
  endtask

  task automatic place_end(input int ptr);
    input_mem[ptr] = {next_random(), 8'hff};
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  task automatic build_expected();
    int         ptr;
    int         n;
    int         np;
    int         sum;
    int         relu;
    int         best;
    logic [7:0] pooled [$];
    for (int i = 0; i < DEPTH; i++)
    begin
      expected_mem[i] = 'x;
    end
    expected_count = 0;
    ptr = 0;
    while (input_mem[ptr][7:0] != 8'hff)
    begin
      n  = input_mem[ptr][7:0];
      np = (n - 2) / 2;
      pooled.delete();
      for (int pr = 0; pr < np; pr++)
      begin
        for (int pc = 0; pc < np; pc++)
        begin
          best = 0;
          for (int q = 0; q < 4; q++)   // 2x2 block of conv outputs
          begin
            sum = 0;
            for (int k = 0; k < 9; k++)
            begin
              sum += weight_at(k) * pixel_at(ptr + 1, n, 2 * pr + q / 2 + k / 3,
                                             2 * pc + q % 2 + k % 3);
            end
            relu = (sum < 0) ? 0 : (sum > 127) ? 127 : sum;
            if (relu > best)
            begin
              best = relu;
            end
          end
          pooled.push_back(8'(best));
        end
      end
      // first result high, odd tail padded with zero
      for (int i = 0; i < pooled.size(); i += 2)
      begin
        expected_mem[expected_count] =
          {pooled[i], (i + 1 < pooled.size()) ? pooled[i + 1] : 8'h00};
        expected_count++;
      end
      ptr += 1 + n * n / 2;
    end
  endtask

  task automatic do_run();
    @(posedge clk);
    #2;
    dut_run = 1'b1;
    @(posedge clk);
    #2;
    dut_run = 1'b0;
    @(negedge clk);
    while (dut_busy)
    begin
      @(negedge clk);
    end
    repeat (20) @(posedge clk);   // idle gap, stray writes would show here
  endtask

  // ----------------------------------------------------------------------
  // stimulus
  // ----------------------------------------------------------------------
  initial
  begin
    int ptr;
    dut_run                = 1'b0;
    reset_b                = 1'b0;
    input_sram_read_data   = '0;
    weights_sram_read_data = '0;
    expected_count         = 0;
    for (int i = 0; i < DEPTH; i++)
    begin
      input_mem[i]    = 16'(i * 40503);
      weights_mem[i]  = 16'(i * 25171) ^ 16'h5a5a;
      expected_mem[i] = 'x;
    end
    repeat (16) @(posedge clk);
    #2;
    reset_b = 1'b1;

    // one random 8x8, nine pooled results
    load_kernel(0);
    ptr = 0;
    place_matrix(ptr, 8, 1'b0);
    place_end(ptr);
    build_expected();
    do_run();

    // positive pixels, saturation then clamping
    load_kernel(1);
    ptr = 0;
    place_matrix(ptr, 6, 1'b1);
    place_end(ptr);
    build_expected();
    do_run();
    load_kernel(2);
    build_expected();
    do_run();

    // three matrices in one run
    load_kernel(0);
    ptr = 0;
    place_matrix(ptr, 6, 1'b0);
    place_matrix(ptr, 4, 1'b0);
    place_matrix(ptr, 10, 1'b0);
    place_end(ptr);
    build_expected();
    do_run();

    // terminator straight away
    place_end(0);
    build_expected();
    do_run();

    $display("TESTS PASSED");
    $finish;
  end

  initial
  begin : watchdog
    int limit;
    limit = 200;
    for (int i = 0; i < $size(TEST_SIZES); i++)
    begin
      limit += 40 * pooled_count(TEST_SIZES[i]);
    end
    repeat (limit) @(posedge clk);
    $display("watchdog expired after %0d cycles, the runs did not complete", limit);
    fail_run();
  end

endmodule

// ==== files.f ====
logic/conv_pkg.sv
logic/run_control.sv
logic/kernel_loader.sv
logic/window_fetch.sv
logic/conv_pool_engine.sv
logic/conv_accel_top.sv
tb/conv_accel_checker.sv
tb/conv_accel_tb.sv
